/* src/gcm_types_pkg.sv */
//==========================================================================
// Data widths and vector types of the GCM block path
//   block_t         one 128-bit GCM block
//   length_t        64-bit bit-length field
//   BLOCK_BITS_LOG2 shift from bit length to block count
//==========================================================================

package gcm_types_pkg;

    // Width of one GCM block
    localparam int unsigned BLOCK_BITS = 128;

    // Each length field is half a block
    localparam int unsigned LENGTH_BITS = BLOCK_BITS / 2;

    // log2 of BLOCK_BITS
    localparam int unsigned BLOCK_BITS_LOG2 = 7;

    // Data, H, E(K,J0), AAD, tag and GHASH state
    typedef logic [BLOCK_BITS-1:0] block_t;

    // AAD and text lengths in bits
    typedef logic [LENGTH_BITS-1:0] length_t;

endpackage

/* src/gcm_ctrl_pkg.sv */
//==========================================================================
// Control definitions of the tag sequencing
//   tag_state_t  per-packet sequencer states
//   ghash_sel_t  source of the block folded into GHASH
//==========================================================================

package gcm_ctrl_pkg;

    // Encoding widths
    localparam int unsigned NB_TAG_STATE = 2;
    localparam int unsigned NB_GHASH_SEL = 2;

    // IDLE waits for start of packet, AAD is the single step after it
    typedef enum logic [NB_TAG_STATE-1:0] {
        IDLE   = 2'd0,
        AAD    = 2'd1,
        TEXT   = 2'd2,
        LENGTH = 2'd3
    } tag_state_t;

    // Block feeding the GHASH step
    typedef enum logic [NB_GHASH_SEL-1:0] {
        SEL_AAD    = 2'd0,
        SEL_TEXT   = 2'd1,
        SEL_LENGTH = 2'd2
    } ghash_sel_t;

endpackage

/* src/ghash_if.sv */
//==========================================================================
// Command bus from the tag sequencer to the GHASH unit
//   seq    sequencer side, drives every command
//   ghash  GHASH side, consumes each command in its cycle
//==========================================================================

interface ghash_if;

    // Zero the accumulator
    logic clear;

    // Fold one block in, one-cycle strobe
    logic absorb;

    // Which block gets folded in
    gcm_ctrl_pkg::ghash_sel_t sel;

    // Absorbed block is the length block
    logic last;

    modport seq (
        output clear,
        output absorb,
        output sel,
        output last
    );

    modport ghash (
        input clear,
        input absorb,
        input sel,
        input last
    );

endinterface

/* src/gf128_multiplier.sv */
//==========================================================================
// Combinational GF(2^128) multiply
//   GCM bit order, bit 0 of the field element is the vector MSB
//   Shift-and-reduce over 128 steps
//==========================================================================

module gf128_multiplier
(
    input  gcm_types_pkg::block_t i_x,
    input  gcm_types_pkg::block_t i_y,
    output gcm_types_pkg::block_t o_z
);

    // Reduction polynomial, 0xE1 in the top byte
    localparam gcm_types_pkg::block_t GF_R = {8'he1, 120'd0};

    always_comb
    begin : l_mult
        gcm_types_pkg::block_t z;
        gcm_types_pkg::block_t v;

        z = '0;
        v = i_y;
        for (int i = 0; i < int'(gcm_types_pkg::BLOCK_BITS); i++)
        begin
            // Field bit i of X sits at vector bit 127-i
            if (i_x[gcm_types_pkg::BLOCK_BITS-1-i])
            begin
                z = z ^ v;
            end
            // Multiply V by x, reduce when the top term falls off
            if (v[0])
            begin
                v = (v >> 1) ^ GF_R;
            end
            else
            begin
                v = v >> 1;
            end
        end
        o_z = z;
    end

endmodule

/* src/ghash_tag_unit.sv */
//==========================================================================
// GHASH accumulator and final tag
//   One block folded in per absorb, Y = (Y ^ X) * H
//   Tag register and tag-check fail flag on the length block
//==========================================================================

module ghash_tag_unit
(
    input  logic                   i_clock,
    input  logic                   i_reset,
    input  logic                   i_encrypt,
    input  gcm_types_pkg::block_t  i_text_block,
    input  gcm_types_pkg::block_t  i_h,
    input  gcm_types_pkg::block_t  i_ej0,
    input  gcm_types_pkg::block_t  i_aad,
    input  gcm_types_pkg::block_t  i_tag,
    input  gcm_types_pkg::length_t i_length_aad,
    input  gcm_types_pkg::length_t i_length_text,
    output gcm_types_pkg::block_t  o_tag,
    output logic                   o_tag_ready,
    output logic                   o_fail,
    ghash_if.ghash                 i_ghash
);

    gcm_types_pkg::block_t block_in;
    gcm_types_pkg::block_t hash_in;
    gcm_types_pkg::block_t product;
    gcm_types_pkg::block_t tag_next;
    gcm_types_pkg::block_t ghash_state;
    logic                  tag_load;

    // Block source, length block is len(A) || len(C)
    always_comb
    begin
        case (i_ghash.sel)
            gcm_ctrl_pkg::SEL_AAD:  block_in = i_aad;
            gcm_ctrl_pkg::SEL_TEXT: block_in = i_text_block;
            default:                block_in = {i_length_aad, i_length_text};
        endcase
    end

    assign hash_in = ghash_state ^ block_in;

    gf128_multiplier u_gf128_multiplier
    (
        .i_x (hash_in),
        .i_y (i_h),
        .o_z (product)
    );

    // Final GHASH value masked with E(K,J0)
    assign tag_next = product ^ i_ej0;
    assign tag_load = i_ghash.absorb && i_ghash.last;

    // Accumulator, zeroed at start of packet
    always_ff @(posedge i_clock)
    begin
        if (i_ghash.clear)
            ghash_state <= '0;
        else if (i_ghash.absorb)
            ghash_state <= product;
    end

    // One-cycle ready pulse after the length block
    always_ff @(posedge i_clock)
    begin
        if (i_reset || i_ghash.clear)
            o_tag_ready <= 1'b0;
        else
            o_tag_ready <= tag_load;
    end

    // Tag check only in decrypt mode
    always_ff @(posedge i_clock)
    begin
        if (i_reset || i_ghash.clear)
            o_fail <= 1'b0;
        else if (tag_load)
            o_fail <= !i_encrypt && (tag_next != i_tag);
    end

    // Tag holds until the next packet's length block
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_tag <= '0;
        else if (tag_load)
            o_tag <= tag_next;
    end

    // Ready is a single pulse per packet
    a_tag_ready_pulse : assert property (@(posedge i_clock) disable iff (i_reset)
        o_tag_ready |=> !o_tag_ready);

endmodule

/* src/tag_sequencer_fsm.sv */
//==========================================================================
// Per-packet tag sequencing
//   IDLE -> AAD -> TEXT -> LENGTH -> IDLE
//   Text beat counter and GHASH block selection
//==========================================================================

module tag_sequencer_fsm
#(
    parameter int NB_TIMER = 10
)
(
    input  logic                   i_clock,
    input  logic                   i_reset,
    input  logic                   i_sop,
    input  logic                   i_valid_text,
    input  gcm_types_pkg::length_t i_length_aad,
    input  gcm_types_pkg::length_t i_length_text,
    output logic                   o_busy,
    ghash_if.seq                   o_ghash
);

    gcm_ctrl_pkg::tag_state_t state;
    gcm_ctrl_pkg::tag_state_t state_next;
    logic [NB_TIMER-1:0]      beats_total;
    logic [NB_TIMER-1:0]      beats_left;
    logic                     last_beat;

    // Number of full text blocks in the packet
    assign beats_total = NB_TIMER'(i_length_text >> gcm_types_pkg::BLOCK_BITS_LOG2);

    assign last_beat = (state == gcm_ctrl_pkg::TEXT) && i_valid_text
                       && (beats_left == NB_TIMER'(1));

    //======================================================================
    // State machine
    //======================================================================

    always_comb
    begin
        state_next = state;
        case (state)
            gcm_ctrl_pkg::IDLE:
                state_next = gcm_ctrl_pkg::IDLE;
            gcm_ctrl_pkg::AAD:
                // No text skips straight to the length block
                state_next = (beats_total == '0) ? gcm_ctrl_pkg::LENGTH : gcm_ctrl_pkg::TEXT;
            gcm_ctrl_pkg::TEXT:
                if (last_beat)
                    state_next = gcm_ctrl_pkg::LENGTH;
            default:
                state_next = gcm_ctrl_pkg::IDLE;
        endcase
        // Start of packet restarts from any state
        if (i_sop)
            state_next = gcm_ctrl_pkg::AAD;
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            state <= gcm_ctrl_pkg::IDLE;
        else
            state <= state_next;
    end

    // Beat counter, loaded once the locked length is visible
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            beats_left <= '0;
        else if (state == gcm_ctrl_pkg::AAD)
            beats_left <= beats_total;
        else if (state == gcm_ctrl_pkg::TEXT && i_valid_text)
            beats_left <= beats_left - 1'b1;
    end

    //======================================================================
    // GHASH commands
    //======================================================================

    assign o_ghash.clear  = i_sop;
    assign o_ghash.absorb = ((state == gcm_ctrl_pkg::AAD) && (i_length_aad != '0))
                            || ((state == gcm_ctrl_pkg::TEXT) && i_valid_text)
                            || (state == gcm_ctrl_pkg::LENGTH);
    assign o_ghash.last   = (state == gcm_ctrl_pkg::LENGTH);

    always_comb
    begin
        case (state)
            gcm_ctrl_pkg::AAD:  o_ghash.sel = gcm_ctrl_pkg::SEL_AAD;
            gcm_ctrl_pkg::TEXT: o_ghash.sel = gcm_ctrl_pkg::SEL_TEXT;
            default:            o_ghash.sel = gcm_ctrl_pkg::SEL_LENGTH;
        endcase
    end

    assign o_busy = (state != gcm_ctrl_pkg::IDLE);

    // Text blocks only enter GHASH on a valid beat
    a_text_absorb_valid : assert property (@(posedge i_clock) disable iff (i_reset)
        (o_ghash.absorb && o_ghash.sel == gcm_ctrl_pkg::SEL_TEXT) |-> i_valid_text);

endmodule

/* src/key_lock_monitor.sv */
//==========================================================================
// Hash subkey register and per-packet locking
//   Key register loaded on key update
//   H, E(K,J0), AAD, lengths and mode locked at start of packet
//   Sticky fault for a key update that collides with a packet
//==========================================================================

module key_lock_monitor
(
    input  logic                   i_clock,
    input  logic                   i_reset,
    input  logic                   i_sop,
    input  logic                   i_update_key,
    input  logic                   i_clear_fault_flags,
    input  logic                   i_rf_static_encrypt,
    input  logic                   i_busy,
    input  gcm_types_pkg::block_t  i_hash_subkey,
    input  gcm_types_pkg::block_t  i_ej0,
    input  gcm_types_pkg::block_t  i_aad,
    input  gcm_types_pkg::length_t i_length_aad,
    input  gcm_types_pkg::length_t i_length_text,
    output gcm_types_pkg::block_t  o_h,
    output gcm_types_pkg::block_t  o_ej0,
    output gcm_types_pkg::block_t  o_aad,
    output gcm_types_pkg::length_t o_length_aad,
    output gcm_types_pkg::length_t o_length_text,
    output logic                   o_encrypt,
    output logic                   o_fault_key_update
);

    gcm_types_pkg::block_t key_reg;
    logic                  fault_set;

    // New subkey waits here until the next packet
    always_ff @(posedge i_clock)
    begin
        if (i_update_key)
            key_reg <= i_hash_subkey;
    end

    // Snapshot for the running packet
    always_ff @(posedge i_clock)
    begin
        if (i_sop)
        begin
            o_h           <= key_reg;
            o_ej0         <= i_ej0;
            o_aad         <= i_aad;
            o_length_aad  <= i_length_aad;
            o_length_text <= i_length_text;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_encrypt <= 1'b0;
        else if (i_sop)
            o_encrypt <= i_rf_static_encrypt;
    end

    // Key update during a packet or on its first cycle
    assign fault_set = i_update_key && (i_sop || i_busy);

    // Sticky, a new event wins over the clear
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_fault_key_update <= 1'b0;
        else if (fault_set)
            o_fault_key_update <= 1'b1;
        else if (i_clear_fault_flags)
            o_fault_key_update <= 1'b0;
    end

    // Fault only rises after a colliding key update
    a_fault_cause : assert property (@(posedge i_clock) disable iff (i_reset)
        $rose(o_fault_key_update) |-> $past(i_update_key && (i_sop || i_busy)));

endmodule

/* src/gcm_tag_engine.sv */
//==========================================================================
// GCM authentication tag engine, top level
//   key_lock_monitor   subkey register, locking, key-update fault
//   tag_sequencer_fsm  per-packet sequencing of GHASH steps
//   ghash_tag_unit     GHASH, tag and tag check
//==========================================================================

module gcm_tag_engine
(
    input  logic                   i_clock,
    input  logic                   i_reset,
    input  logic                   i_sop,
    input  logic                   i_valid_text,
    input  logic                   i_update_key,
    input  logic                   i_rf_static_encrypt,
    input  logic                   i_clear_fault_flags,
    input  gcm_types_pkg::block_t  i_text_block,
    input  gcm_types_pkg::block_t  i_hash_subkey,
    input  gcm_types_pkg::block_t  i_ej0,
    input  gcm_types_pkg::block_t  i_aad,
    input  gcm_types_pkg::block_t  i_tag,
    input  gcm_types_pkg::length_t i_length_aad,
    input  gcm_types_pkg::length_t i_length_text,
    output gcm_types_pkg::block_t  o_tag,
    output logic                   o_tag_ready,
    output logic                   o_fail,
    output logic                   o_fault_key_update
);

    // Text beat counter width
    localparam int NB_TIMER = 10;

    // Locked per-packet values
    gcm_types_pkg::block_t  h_locked;
    gcm_types_pkg::block_t  ej0_locked;
    gcm_types_pkg::block_t  aad_locked;
    gcm_types_pkg::length_t length_aad_locked;
    gcm_types_pkg::length_t length_text_locked;
    logic                   encrypt_locked;
    logic                   busy;

    ghash_if u_ghash_if ();

    key_lock_monitor u_key_lock_monitor
    (
        .i_clock             (i_clock),
        .i_reset             (i_reset),
        .i_sop               (i_sop),
        .i_update_key        (i_update_key),
        .i_clear_fault_flags (i_clear_fault_flags),
        .i_rf_static_encrypt (i_rf_static_encrypt),
        .i_busy              (busy),
        .i_hash_subkey       (i_hash_subkey),
        .i_ej0               (i_ej0),
        .i_aad               (i_aad),
        .i_length_aad        (i_length_aad),
        .i_length_text       (i_length_text),
        .o_h                 (h_locked),
        .o_ej0               (ej0_locked),
        .o_aad               (aad_locked),
        .o_length_aad        (length_aad_locked),
        .o_length_text       (length_text_locked),
        .o_encrypt           (encrypt_locked),
        .o_fault_key_update  (o_fault_key_update)
    );

    tag_sequencer_fsm
    #(
        .NB_TIMER (NB_TIMER)
    )
    u_tag_sequencer_fsm
    (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_sop         (i_sop),
        .i_valid_text  (i_valid_text),
        .i_length_aad  (length_aad_locked),
        .i_length_text (length_text_locked),
        .o_busy        (busy),
        .o_ghash       (u_ghash_if.seq)
    );

    ghash_tag_unit u_ghash_tag_unit
    (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_encrypt     (encrypt_locked),
        .i_text_block  (i_text_block),
        .i_h           (h_locked),
        .i_ej0         (ej0_locked),
        .i_aad         (aad_locked),
        .i_tag         (i_tag),
        .i_length_aad  (length_aad_locked),
        .i_length_text (length_text_locked),
        .o_tag         (o_tag),
        .o_tag_ready   (o_tag_ready),
        .o_fail        (o_fail),
        .i_ghash       (u_ghash_if.ghash)
    );

endmodule

/* sim/tb_gcm_tag_engine.sv */
//==========================================================================
// Testbench for the GCM authentication tag engine
//   Clock, reset and packet stimulus
//   Reference GHASH and tag model
//   Compare process, check tasks and watchdog
//==========================================================================

module tb_gcm_tag_engine;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLOCK_PERIOD = 4;
    localparam int RESET_CYCLES = 4;
    localparam int MAX_BEATS    = 8;
    localparam int MAX_GAP      = 3;
    localparam int READY_WAIT   = 8;
    localparam int NUM_TESTS    = 6;
    localparam int NUM_PACKETS  = 8;
    // Start, AAD, length, ready and hold checks
    localparam int PACKET_FRAME = 8;
    localparam int PACKET_BEATS [NUM_PACKETS] = '{4, 4, 4, 0, 6, 6, 4, 4};
    localparam int TAG_RANDOM   = 0;
    localparam int TAG_MATCH    = 1;
    localparam int TAG_FLIP     = 2;
    localparam logic [31:0] SEED = 32'hdd2e_cd24;

    // DUT ports
    logic                   i_clock;
    logic                   i_reset;
    logic                   i_sop;
    logic                   i_valid_text;
    logic                   i_update_key;
    logic                   i_rf_static_encrypt;
    logic                   i_clear_fault_flags;
    gcm_types_pkg::block_t  i_text_block;
    gcm_types_pkg::block_t  i_hash_subkey;
    gcm_types_pkg::block_t  i_ej0;
    gcm_types_pkg::block_t  i_aad;
    gcm_types_pkg::block_t  i_tag;
    gcm_types_pkg::length_t i_length_aad;
    gcm_types_pkg::length_t i_length_text;
    gcm_types_pkg::block_t  o_tag;
    logic                   o_tag_ready;
    logic                   o_fail;
    logic                   o_fault_key_update;

    // Bookkeeping
    int error_count  = 0;
    int done_count   = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int cycle_count  = 0;

    // Expected results, one entry per packet
    gcm_types_pkg::block_t exp_tag_q [$];
    logic                  exp_fail_q [$];
    int                    exp_cycle_q [$];

    // Model of the DUT key register
    gcm_types_pkg::block_t key_model;

    // Current packet contents
    gcm_types_pkg::block_t  pkt_blocks [MAX_BEATS];
    gcm_types_pkg::block_t  pkt_ej0;
    gcm_types_pkg::block_t  pkt_aad;
    gcm_types_pkg::length_t pkt_len_aad;
    gcm_types_pkg::length_t pkt_len_text;
    int                     pkt_beats;

    gcm_tag_engine dut0
    (
        .i_clock             (i_clock),
        .i_reset             (i_reset),
        .i_sop               (i_sop),
        .i_valid_text        (i_valid_text),
        .i_update_key        (i_update_key),
        .i_rf_static_encrypt (i_rf_static_encrypt),
        .i_clear_fault_flags (i_clear_fault_flags),
        .i_text_block        (i_text_block),
        .i_hash_subkey       (i_hash_subkey),
        .i_ej0               (i_ej0),
        .i_aad               (i_aad),
        .i_tag               (i_tag),
        .i_length_aad        (i_length_aad),
        .i_length_text       (i_length_text),
        .o_tag               (o_tag),
        .o_tag_ready         (o_tag_ready),
        .o_fail              (o_fail),
        .o_fault_key_update  (o_fault_key_update)
    );

    initial
    begin : clock_gen
        i_clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) i_clock = ~i_clock;
    end

    // Cycle index for the timing checks
    always @(posedge i_clock)
        cycle_count <= cycle_count + 1;

    //======================================================================
    // Reference model
    //======================================================================

    function automatic gcm_types_pkg::block_t rand_block();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    // GF(2^128) product with field bit 0 as the vector MSB
    function automatic gcm_types_pkg::block_t gf_mul(input gcm_types_pkg::block_t x,
                                                     input gcm_types_pkg::block_t y);
        gcm_types_pkg::block_t z;
        gcm_types_pkg::block_t v;
        gcm_types_pkg::block_t xs;

        z  = '0;
        v  = y;
        xs = x;
        repeat (128)
        begin
            if (xs[127])
                z = z ^ v;
            // Multiply V by x and fold back with R = 0xE1 || 0^120
            v  = v[0] ? ((v >> 1) ^ {8'he1, 120'h0}) : (v >> 1);
            xs = xs << 1;
        end
        return z;
    endfunction

    // GHASH over AAD, text and length block, masked with E(K,J0)
    function automatic gcm_types_pkg::block_t ref_ghash_tag(
        input gcm_types_pkg::block_t  h,
        input gcm_types_pkg::block_t  ej0,
        input gcm_types_pkg::block_t  aad,
        input gcm_types_pkg::length_t len_aad,
        input gcm_types_pkg::length_t len_text,
        input gcm_types_pkg::block_t  blocks [MAX_BEATS],
        input int                     n_beats);
        gcm_types_pkg::block_t y;

        y = '0;
        if (len_aad != '0)
            y = gf_mul(y ^ aad, h);
        for (int i = 0; i < n_beats; i++)
            y = gf_mul(y ^ blocks[i], h);
        y = gf_mul(y ^ {len_aad, len_text}, h);
        return y ^ ej0;
    endfunction

    //======================================================================
    // Check and report tasks
    //======================================================================

    task automatic check_block(input string name, input gcm_types_pkg::block_t got,
                               input gcm_types_pkg::block_t exp);
        if (got !== exp)
        begin
            $display("[FAIL] %s: got 0x%032h, expected 0x%032h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_cycle(input string name, input int got, input int exp);
        if (got != exp)
        begin
            $display("[FAIL] %s: got cycle 0x%0h, expected 0x%0h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int errors_before);
        if (error_count == errors_before)
        begin
            tests_passed++;
            $display("test %0d %s: passed", num, name);
        end
        else
        begin
            tests_failed++;
            $display("test %0d %s: %0d errors", num, name, error_count - errors_before);
        end
    endtask

    //======================================================================
    // Stimulus tasks
    //======================================================================

    task automatic load_key(input gcm_types_pkg::block_t h);
        @(posedge i_clock);
        i_update_key  <= 1'b1;
        i_hash_subkey <= h;
        @(posedge i_clock);
        i_update_key  <= 1'b0;
        key_model = h;
    endtask

    task automatic make_packet(input int n_beats, input logic has_aad);
        pkt_beats = n_beats;
        for (int i = 0; i < MAX_BEATS; i++)
            pkt_blocks[i] = rand_block();
        pkt_ej0      = rand_block();
        pkt_aad      = rand_block();
        pkt_len_aad  = has_aad ? gcm_types_pkg::length_t'($urandom_range(128, 1)) : '0;
        pkt_len_text = gcm_types_pkg::length_t'(n_beats * 128);
    endtask

    // One packet, optional gaps and a key update on the first beat
    task automatic run_packet(input logic enc, input int max_gap, input int tag_mode,
                              input logic upd_key, input gcm_types_pkg::block_t new_h);
        gcm_types_pkg::block_t exp_tag;
        gcm_types_pkg::block_t tag_in;
        logic                  exp_fail;
        int                    last_cycle;
        int                    gap;
        int                    done_before;
        int                    waited;

        // Key in force at start of packet
        exp_tag = ref_ghash_tag(key_model, pkt_ej0, pkt_aad, pkt_len_aad, pkt_len_text,
                                pkt_blocks, pkt_beats);
        if (tag_mode == TAG_MATCH)
            tag_in = exp_tag;
        else if (tag_mode == TAG_FLIP)
            tag_in = exp_tag ^ (gcm_types_pkg::block_t'(1) << $urandom_range(127, 0));
        else
            tag_in = rand_block();
        // Only a matching tag passes the check in decrypt mode
        exp_fail    = !enc && (tag_mode != TAG_MATCH);
        done_before = done_count;

        // Cycle s
        @(posedge i_clock);
        i_sop               <= 1'b1;
        i_rf_static_encrypt <= enc;
        i_ej0               <= pkt_ej0;
        i_aad               <= pkt_aad;
        i_length_aad        <= pkt_len_aad;
        i_length_text       <= pkt_len_text;
        i_tag               <= tag_in;

        // Scramble the values that must be locked in cycle s+1
        @(posedge i_clock);
        i_sop               <= 1'b0;
        i_rf_static_encrypt <= !enc;
        i_ej0               <= rand_block();
        i_aad               <= rand_block();
        i_length_aad        <= {$urandom, $urandom};
        i_length_text       <= {$urandom, $urandom};
        last_cycle = cycle_count + 1;

        for (int i = 0; i < pkt_beats; i++)
        begin
            gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
            repeat (gap)
            begin
                @(posedge i_clock);
                i_valid_text <= 1'b0;
                i_update_key <= 1'b0;
                i_text_block <= rand_block();
            end
            @(posedge i_clock);
            i_valid_text  <= 1'b1;
            i_text_block  <= pkt_blocks[i];
            i_update_key  <= upd_key && (i == 0);
            i_hash_subkey <= new_h;
            last_cycle = cycle_count + 1;
        end

        @(posedge i_clock);
        i_valid_text <= 1'b0;
        i_update_key <= 1'b0;
        i_text_block <= rand_block();
        if (upd_key && pkt_beats > 0)
            key_model = new_h;

        // Ready two cycles after the last beat, or s+3 without text
        exp_tag_q.push_back(exp_tag);
        exp_fail_q.push_back(exp_fail);
        exp_cycle_q.push_back(last_cycle + 2);

        waited = 0;
        while (done_count == done_before && waited < READY_WAIT)
        begin
            @(posedge i_clock);
            waited++;
        end
        if (done_count == done_before)
        begin
            $display("ERROR: no o_tag_ready pulse within %0d cycles of the text", READY_WAIT);
            error_count++;
            exp_tag_q.delete();
            exp_fail_q.delete();
            exp_cycle_q.delete();
        end
        else
        begin
            // Tag and fail hold after the pulse
            repeat (2) @(negedge i_clock);
            check_block("o_tag after ready", o_tag, exp_tag);
            check_flag("o_fail after ready", o_fail, exp_fail);
        end
    endtask

    //======================================================================
    // Compare process
    //======================================================================

    initial
    begin : compare_results
        gcm_types_pkg::block_t exp_tag;
        logic                  exp_fail;
        int                    exp_cycle;

        forever
        begin
            @(negedge i_clock);
            if (o_tag_ready === 1'b1)
            begin
                if (exp_cycle_q.size() == 0)
                begin
                    $display("ERROR: o_tag_ready pulsed with no packet pending");
                    error_count++;
                end
                else
                begin
                    exp_tag   = exp_tag_q.pop_front();
                    exp_fail  = exp_fail_q.pop_front();
                    exp_cycle = exp_cycle_q.pop_front();
                    check_block("o_tag", o_tag, exp_tag);
                    check_flag("o_fail", o_fail, exp_fail);
                    check_cycle("o_tag_ready", cycle_count, exp_cycle);
                end
                done_count++;
            end
        end
    end

    // Limit from packet lengths plus 20 cycles per test
    initial
    begin : watchdog
        int limit_cycles;

        limit_cycles = RESET_CYCLES + 20 * NUM_TESTS;
        for (int i = 0; i < NUM_PACKETS; i++)
            limit_cycles += PACKET_BEATS[i] * (MAX_GAP + 1) + PACKET_FRAME;
        #(limit_cycles * CLOCK_PERIOD);
        $display("ERROR: watchdog expired after %0d cycles", limit_cycles);
        $display("Simulation failed");
        $finish;
    end

    //======================================================================
    // Test sequence
    //======================================================================

    initial
    begin : main_sequence
        int                    errors_before;
        gcm_types_pkg::block_t new_h;

        void'($urandom(SEED));
        i_reset             <= 1'b1;
        i_sop               <= 1'b0;
        i_valid_text        <= 1'b0;
        i_update_key        <= 1'b0;
        i_rf_static_encrypt <= 1'b0;
        i_clear_fault_flags <= 1'b0;
        i_text_block        <= '0;
        i_hash_subkey       <= '0;
        i_ej0               <= '0;
        i_aad               <= '0;
        i_tag               <= '0;
        i_length_aad        <= '0;
        i_length_text       <= '0;
        repeat (RESET_CYCLES) @(posedge i_clock);
        i_reset <= 1'b0;
        load_key(rand_block());

        errors_before = error_count;
        make_packet(4, 1'b1);
        run_packet(1'b1, 0, TAG_RANDOM, 1'b0, '0);
        report_test(1, "encrypt with AAD and 4 beats", errors_before);

        errors_before = error_count;
        make_packet(4, 1'b1);
        run_packet(1'b0, 0, TAG_MATCH, 1'b0, '0);
        report_test(2, "decrypt with matching tag", errors_before);

        errors_before = error_count;
        make_packet(4, 1'b1);
        run_packet(1'b0, 0, TAG_FLIP, 1'b0, '0);
        report_test(3, "decrypt with one tag bit flipped", errors_before);

        errors_before = error_count;
        make_packet(0, 1'b0);
        run_packet(1'b1, 0, TAG_RANDOM, 1'b0, '0);
        report_test(4, "empty AAD and text", errors_before);

        // Same packet back to back, then with gaps
        errors_before = error_count;
        make_packet(6, 1'b1);
        run_packet(1'b1, 0, TAG_RANDOM, 1'b0, '0);
        run_packet(1'b1, MAX_GAP, TAG_RANDOM, 1'b0, '0);
        report_test(5, "text beats with random gaps", errors_before);

        // Key update collides with a running packet
        errors_before = error_count;
        @(negedge i_clock);
        check_flag("o_fault_key_update before packet", o_fault_key_update, 1'b0);
        new_h = rand_block();
        make_packet(4, 1'b1);
        run_packet(1'b1, 0, TAG_RANDOM, 1'b1, new_h);
        repeat (3) @(negedge i_clock);
        check_flag("o_fault_key_update held", o_fault_key_update, 1'b1);
        @(posedge i_clock);
        i_clear_fault_flags <= 1'b1;
        @(posedge i_clock);
        i_clear_fault_flags <= 1'b0;
        @(negedge i_clock);
        check_flag("o_fault_key_update after clear", o_fault_key_update, 1'b0);
        make_packet(4, 1'b1);
        run_packet(1'b0, 0, TAG_MATCH, 1'b0, '0);
        check_flag("o_fault_key_update next packet", o_fault_key_update, 1'b0);
        report_test(6, "key update during a packet", errors_before);

        $display("tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0)
        begin
            $display("Simulation completed successfully");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* files.f */
src/gcm_types_pkg.sv
src/gcm_ctrl_pkg.sv
src/ghash_if.sv
src/gf128_multiplier.sv
src/ghash_tag_unit.sv
src/tag_sequencer_fsm.sv
src/key_lock_monitor.sv
src/gcm_tag_engine.sv
sim/tb_gcm_tag_engine.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the GCM tag engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module tb_gcm_tag_engine -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build error"
    exit 1
fi

./obj_dir/Vtb_gcm_tag_engine > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0
